// ==== build.f ====
design/bch_pkg.sv
design/bch_encoder.sv
design/bch_syndrome.sv
design/bch_err_pat_dcd.sv
design/bch_decoder.sv
design/bch_codec_top.sv
tb/tb_bch_codec.sv

// ==== tb/tb_bch_codec.sv ====
// data_width fixed at 16 here; stops at the first mismatch; decode model brute forces up to two flips

module tb_bch_codec;

  localparam int data_width = 16;
  localparam int p_w        = bch_pkg::parity_width;
  localparam int cw_w       = data_width + p_w;
  localparam int period     = 20;
  localparam int n_enc      = 300;
  localparam int n_dec      = 120;
  // encode phase plus five decode phases
  localparam int total_vec  = n_enc + 5 * n_dec;
  localparam int wd_cycles  = total_vec * 4 + 100;

  // own copy of g(x) = x^10+x^9+x^8+x^6+x^5+x^3+1
  localparam logic [10:0] gen_ref = 11'b111_0110_1001;

  // expected decoder result
  typedef struct packed {
    logic [data_width-1:0] data;
    bch_pkg::bch_status_t  status;
  } dec_exp_t;

  logic                  clk;
  logic                  arst_n;
  logic                  enc_valid;
  logic [data_width-1:0] enc_data;
  logic                  enc_out_valid;
  logic [cw_w-1:0]       enc_codeword;
  logic                  dec_valid;
  logic [cw_w-1:0]       dec_codeword;
  logic                  dec_out_valid;
  logic [data_width-1:0] dec_data;
  bch_pkg::bch_status_t  dec_status;

  // alpha^i table, x^5+x^2+1
  logic [4:0]            alog [0:30];
  logic [31:0]           rng_state;
  // scoreboard
  logic [cw_w-1:0]       enc_q [$];
  dec_exp_t              dec_q [$];
  logic [cw_w-1:0]       exp_cw;
  dec_exp_t              exp_dec;
  // valid history for the fixed latencies
  logic                  enc_hist;
  logic [1:0]            dec_hist;
  // last outputs for the hold check
  logic [cw_w-1:0]       enc_last;
  logic [data_width-1:0] dec_last;

  bch_codec_top #(
    .data_width(data_width)
  ) DUT (
    .clk          (clk),
    .arst_n       (arst_n),
    .enc_valid    (enc_valid),
    .enc_data     (enc_data),
    .enc_out_valid(enc_out_valid),
    .enc_codeword (enc_codeword),
    .dec_valid    (dec_valid),
    .dec_codeword (dec_codeword),
    .dec_out_valid(dec_out_valid),
    .dec_data     (dec_data),
    .dec_status   (dec_status)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // ##########################################################
  // reference model
  // ##########################################################

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic build_alog();
    logic [4:0] a;
    a = 5'd1;
    for (int i = 0; i < 31; i++) begin
      alog[i] = a;
      // fold x^5 back as x^2+1
      a = {a[3:0], 1'b0} ^ (a[4] ? 5'b00101 : 5'b00000);
    end
  endtask

  // long division of d(x)*x^10 by g(x), top bit first
  function automatic logic [p_w-1:0] model_parity(input logic [data_width-1:0] d);
    logic [30:0] r;
    r = 31'(d) << p_w;
    for (int b = 30; b >= p_w; b--) begin
      if (r[b]) begin
        r = r ^ (31'(gen_ref) << (b - p_w));
      end
    end
    return r[p_w-1:0];
  endfunction

  // {s1, s3} of a word
  function automatic logic [9:0] model_synd(input logic [cw_w-1:0] w);
    logic [4:0] s1;
    logic [4:0] s3;
    s1 = '0;
    s3 = '0;
    for (int j = 0; j < cw_w; j++) begin
      if (w[j]) begin
        s1 = s1 ^ alog[j];
        s3 = s3 ^ alog[(3 * j) % 31];
      end
    end
    return {s1, s3};
  endfunction

  // single flips over all 31 positions, pairs only inside the shortened word
  function automatic dec_exp_t model_decode(input logic [cw_w-1:0] rx);
    logic [9:0]  syn;
    logic [30:0] fix;
    logic        found;
    dec_exp_t    r;
    syn      = model_synd(rx);
    fix      = '0;
    found    = 1'b0;
    r.status = '0;
    if (syn != '0) begin
      for (int j = 0; j < 31; j++) begin
        if (!found && {alog[j], alog[(3 * j) % 31]} == syn) begin
          found           = 1'b1;
          fix[j]          = 1'b1;
          r.status.err_cnt = 2'd1;
        end
      end
      for (int i = 0; i < cw_w; i++) begin
        for (int k = i + 1; k < cw_w; k++) begin
          if (!found &&
              {alog[i] ^ alog[k], alog[(3 * i) % 31] ^ alog[(3 * k) % 31]} == syn) begin
            found            = 1'b1;
            fix[i]           = 1'b1;
            fix[k]           = 1'b1;
            r.status.err_cnt = 2'd2;
          end
        end
      end
      // nothing within two flips
      r.status.uncorrectable = !found;
    end
    // parity and out of range flips never touch data
    r.data = rx[cw_w-1:p_w] ^ fix[cw_w-1:p_w];
    return r;
  endfunction

  // ##########################################################
  // checks and stimulus
  // ##########################################################

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic send_enc();
    logic [data_width-1:0] d;
    rng_state = xorshift32(rng_state);
    d         = rng_state[data_width-1:0];
    enc_q.push_back({d, model_parity(d)});
    @(posedge clk);
    enc_valid <= 1'b1;
    enc_data  <= d;
  endtask

  // n_err distinct flips anywhere in the word
  task automatic send_dec(input int n_err);
    logic [data_width-1:0] d;
    logic [cw_w-1:0]       cw;
    logic [cw_w-1:0]       rx;
    int                    pos;
    dec_exp_t              e;
    rng_state = xorshift32(rng_state);
    d         = rng_state[data_width-1:0];
    cw        = {d, model_parity(d)};
    rx        = cw;
    for (int k = 0; k < n_err; k++) begin
      // redraw until the position is not flipped yet
      do begin
        rng_state = xorshift32(rng_state);
        pos       = int'(rng_state % cw_w);
      end while (rx[pos] != cw[pos]);
      rx[pos] = ~rx[pos];
    end
    if (n_err < 3) begin
      // up to two errors always come back clean
      e.data                 = d;
      e.status.err_cnt       = 2'(n_err);
      e.status.uncorrectable = 1'b0;
    end else begin
      e = model_decode(rx);
    end
    dec_q.push_back(e);
    @(posedge clk);
    dec_valid    <= 1'b1;
    dec_codeword <= rx;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    enc_valid <= 1'b0;
    dec_valid <= 1'b0;
  endtask

  // idle about one slot in four
  task automatic maybe_gap();
    rng_state = xorshift32(rng_state);
    if (rng_state[5:4] == 2'd0) begin
      idle_cycle();
    end
  endtask

  // ##########################################################
  // monitor at the falling edge
  // ##########################################################

  always @(negedge clk) begin
    // outputs are defined once reset is released
    if (arst_n === 1'b1) begin
      check_eq("enc_out_valid", 64'(enc_hist), 64'(enc_out_valid));
      if (enc_hist) begin
        exp_cw = enc_q.pop_front();
        check_eq("enc_codeword", 64'(exp_cw), 64'(enc_codeword));
        enc_last = enc_codeword;
      end else begin
        check_eq("enc_codeword", 64'(enc_last), 64'(enc_codeword));
      end
      check_eq("dec_out_valid", 64'(dec_hist[1]), 64'(dec_out_valid));
      if (dec_hist[1]) begin
        exp_dec = dec_q.pop_front();
        check_eq("dec_data", 64'(exp_dec.data), 64'(dec_data));
        check_eq("dec_status", 64'(exp_dec.status), 64'(dec_status));
        dec_last = dec_data;
      end else begin
        check_eq("dec_data", 64'(dec_last), 64'(dec_data));
      end
    end
    enc_hist = enc_valid;
    dec_hist = {dec_hist[0], dec_valid};
  end

  // ##########################################################
  // main sequence
  // ##########################################################

  initial begin
    rng_state    = 32'd75094;
    arst_n       = 1'b0;
    enc_valid    = 1'b0;
    enc_data     = '0;
    dec_valid    = 1'b0;
    dec_codeword = '0;
    enc_hist     = 1'b0;
    dec_hist     = 2'b00;
    enc_last     = '0;
    dec_last     = '0;
    build_alog();
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_eq("enc_out_valid", 64'd0, 64'(enc_out_valid));
    check_eq("dec_out_valid", 64'd0, 64'(dec_out_valid));
    // encoder against model parity
    for (int i = 0; i < n_enc; i++) begin
      send_enc();
      maybe_gap();
    end
    idle_cycle();
    // clean, single, double and triple errors
    for (int ne = 0; ne < 4; ne++) begin
      for (int i = 0; i < n_dec; i++) begin
        send_dec(ne);
        maybe_gap();
      end
      idle_cycle();
    end
    // back to back, mixed counts
    for (int i = 0; i < n_dec; i++) begin
      rng_state = xorshift32(rng_state);
      send_dec(int'(rng_state % 4));
    end
    idle_cycle();
    // drain the pipes
    repeat (4) @(posedge clk);
    @(negedge clk);
    if (enc_q.size() != 0 || dec_q.size() != 0) begin
      $display("results lost: %0d encode and %0d decode words never came out",
               enc_q.size(), dec_q.size());
      $display("FAIL: see errors above");
      $fatal(1);
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

  // watchdog
  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("run hung, no end after %0d cycles", wd_cycles);
    $display("FAIL: see errors above");
    $fatal(1);
  end

endmodule

// ==== design/bch_codec_top.sv ====
// BCH(31,21) DEC codec shortened to data_width 1..21; encode 1 cycle, decode 2 cycles

module bch_codec_top #(
  parameter int data_width = 16
) (
  input  logic                                        clk,
  input  logic                                        arst_n,
  // encode path
  input  logic                                        enc_valid,
  input  logic [data_width-1:0]                       enc_data,
  output logic                                        enc_out_valid,
  output logic [data_width+bch_pkg::parity_width-1:0] enc_codeword,
  // decode path
  input  logic                                        dec_valid,
  input  logic [data_width+bch_pkg::parity_width-1:0] dec_codeword,
  output logic                                        dec_out_valid,
  output logic [data_width-1:0]                       dec_data,
  output bch_pkg::bch_status_t                        dec_status
);

  // shortened word must fit in 31 bits
  if (data_width < 1 || data_width > bch_pkg::max_data_width) begin : g_width_check
    $error("bch_codec_top data_width out of range 1..21");
  end

  // ##########################################################
  // independent encode and decode paths
  // ##########################################################

  bch_encoder #(
    .data_width(data_width)
  ) u_encoder (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (enc_valid),
    .in_data  (enc_data),
    .out_valid(enc_out_valid),
    .codeword (enc_codeword)
  );

  bch_decoder #(
    .data_width(data_width)
  ) u_decoder (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (dec_valid),
    .codeword (dec_codeword),
    .out_valid(dec_out_valid),
    .data     (dec_data),
    .status   (dec_status)
  );

endmodule

// ==== design/bch_decoder.sv ====
// two-stage DEC decoder; data_width 1..21, a word per cycle, no stall, uncorrectable passes data raw

module bch_decoder #(
  parameter int data_width = 16
) (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        in_valid,
  input  logic [data_width+bch_pkg::parity_width-1:0] codeword,
  output logic                                        out_valid,
  output logic [data_width-1:0]                       data,
  output bch_pkg::bch_status_t                        status
);

  // stage 1 outputs
  logic                  synd_valid;
  bch_pkg::bch_synd_t    synd_q;
  logic [data_width-1:0] rx_data;

  // pattern decoder outputs
  logic [data_width-1:0] err_mask;
  bch_pkg::bch_status_t  pat_status;

  // ##########################################################
  // stage 1 syndromes
  // ##########################################################

  bch_syndrome #(
    .data_width(data_width)
  ) u_syndrome (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .codeword (codeword),
    .out_valid(synd_valid),
    .synd     (synd_q),
    .data     (rx_data)
  );

  // mask from registered syndromes
  bch_err_pat_dcd #(
    .data_width(data_width)
  ) u_pat_dcd (
    .synd  (synd_q),
    .mask  (err_mask),
    .status(pat_status)
  );

  // ##########################################################
  // stage 2 correction
  // ##########################################################

  // flip marked data bits
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      data      <= '0;
      status    <= '0;
    end else begin
      out_valid <= synd_valid;
      if (synd_valid) begin
        data   <= rx_data ^ err_mask;
        status <= pat_status;
      end
    end
  end

  // uncorrectable words leave the decoder untouched
  a_no_fix_on_fail : assert property (
    @(posedge clk) disable iff (!arst_n)
    synd_valid |-> (!pat_status.uncorrectable || (err_mask == '0))
  );

  // parity hits drop out of the mask so it can only be smaller
  a_mask_weight : assert property (
    @(posedge clk) disable iff (!arst_n)
    synd_valid |-> ($countones(err_mask) <= int'(pat_status.err_cnt))
  );

endmodule

// ==== design/bch_err_pat_dcd.sv ====
// combinational DEC pattern decoder for GF(32); data_width 1..21, mask covers data bits only

module bch_err_pat_dcd #(
  parameter int data_width = 16
) (
  input  bch_pkg::bch_synd_t    synd,
  output logic [data_width-1:0] mask,
  output bch_pkg::bch_status_t  status
);

  localparam int n_len = data_width + bch_pkg::parity_width;
  localparam int p_w   = bch_pkg::parity_width;

  // syndrome terms
  bch_pkg::gf_t s1_sq;
  bch_pkg::gf_t s1_cu;
  bch_pkg::gf_t sigma2;
  logic         s1_zero;
  logic         s3_zero;

  // per-position results over the shortened word
  logic [n_len-1:0] single_hit;
  logic [n_len-1:0] root_hit;
  logic [5:0]       root_cnt;

  // ##########################################################
  // locator coefficients
  // ##########################################################

  assign s1_zero = (synd.s1 == '0);
  assign s3_zero = (synd.s3 == '0);

  assign s1_sq = bch_pkg::gf_sq(synd.s1);
  // one error gives s3 = s1^3
  assign s1_cu = bch_pkg::gf_mul(s1_sq, synd.s1);

  // product of the two locators
  // X1*X2 = s1^2 + s3/s1
  assign sigma2 = s1_sq ^ bch_pkg::gf_mul(synd.s3, bch_pkg::gf_inv(synd.s1));

  // ##########################################################
  // parallel position tests
  // ##########################################################

  // locator z^2 + s1*z + sigma2 at z = alpha^j
  // alpha^j and alpha^2j are constants per position
  for (genvar j = 0; j < n_len; j++) begin : g_pos
    localparam bch_pkg::gf_t alpha_j  = bch_pkg::gf_pow_alpha(j);
    localparam bch_pkg::gf_t alpha_2j = bch_pkg::gf_pow_alpha(2 * j);

    // single error locator equals s1
    assign single_hit[j] = (synd.s1 == alpha_j);

    assign root_hit[j] = ((alpha_2j ^ bch_pkg::gf_mul(synd.s1, alpha_j) ^ sigma2) == '0);
  end

  // roots outside the shortened length are never counted
  assign root_cnt = 6'($countones(root_hit));

  // ##########################################################
  // decision
  // ##########################################################

  always_comb begin
    mask   = '0;
    status = '0;
    if (s1_zero) begin
      // clean word when s3 is also zero
      // s3 alone cannot come from one or two errors
      status.uncorrectable = !s3_zero;
    end else if (synd.s3 == s1_cu) begin
      // one error
      // a hit in parity leaves the data as is
      status.err_cnt = 2'd1;
      mask           = single_hit[n_len-1:p_w];
    end else if (root_cnt == 6'd2) begin
      status.err_cnt = 2'd2;
      // upper slice only, as with the full-length mask bus
      mask           = root_hit[n_len-1:p_w];
    end else begin
      // too many errors or roots off the shortened word
      status.uncorrectable = 1'b1;
    end
  end

endmodule

// ==== design/bch_syndrome.sv ====
// S1 and S3 of a shortened codeword; data_width must be 1..21, result registered one cycle

module bch_syndrome #(
  parameter int data_width = 16
) (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        in_valid,
  input  logic [data_width+bch_pkg::parity_width-1:0] codeword,
  output logic                                        out_valid,
  output bch_pkg::bch_synd_t                          synd,
  output logic [data_width-1:0]                       data
);

  // shortened length
  localparam int n_len = data_width + bch_pkg::parity_width;

  // next syndromes
  bch_pkg::bch_synd_t synd_d;

  // ##########################################################
  // syndrome sums
  // ##########################################################

  // r(alpha) and r(alpha^3)
  // each set bit j adds alpha^j and alpha^3j
  // exponents are constants so this is an xor tree
  always_comb begin
    synd_d = '0;
    for (int j = 0; j < n_len; j++) begin
      if (codeword[j]) begin
        synd_d.s1 = synd_d.s1 ^ bch_pkg::gf_pow_alpha(j);
        // 3j wraps mod 31 inside the function
        synd_d.s3 = synd_d.s3 ^ bch_pkg::gf_pow_alpha(3 * j);
      end
    end
  end

  // ##########################################################
  // stage register
  // ##########################################################

  // data bits ride along for the correction stage
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      synd      <= '0;
      data      <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        synd <= synd_d;
        // upper slice holds the data
        data <= codeword[n_len-1:bch_pkg::parity_width];
      end
    end
  end

  // a defined strobe must leave defined syndromes behind it
  // catches X on the codeword reaching the pattern decoder
  a_synd_known : assert property (
    @(posedge clk) disable iff (!arst_n)
    !$isunknown(in_valid) |=> !$isunknown(synd)
  );

endmodule

// ==== design/bch_encoder.sv ====
// systematic encoder; data_width must be 1..21, parity on bits 9:0, one word per cycle

module bch_encoder #(
  parameter int data_width = 16
) (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        in_valid,
  input  logic [data_width-1:0]                       in_data,
  output logic                                        out_valid,
  output logic [data_width+bch_pkg::parity_width-1:0] codeword
);

  localparam int p_w = bch_pkg::parity_width;

  // remainder of d(x) * x^10 mod g(x)
  logic [p_w-1:0] parity;

  // syndromes of the registered word
  bch_pkg::bch_synd_t cw_synd;

  // ##########################################################
  // unrolled division
  // ##########################################################

  // same as a serial LFSR, one step per data bit
  // data MSB enters first
  always_comb begin
    parity = '0;
    for (int i = data_width - 1; i >= 0; i--) begin
      // feedback is incoming bit against the top remainder bit
      if (in_data[i] ^ parity[p_w-1]) begin
        parity = {parity[p_w-2:0], 1'b0} ^ bch_pkg::gen_poly[p_w-1:0];
      end else begin
        parity = {parity[p_w-2:0], 1'b0};
      end
    end
  end

  // ##########################################################
  // output register
  // ##########################################################

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      codeword  <= '0;
    end else begin
      out_valid <= in_valid;
      // hold last word between strobes
      if (in_valid) begin
        codeword <= {in_data, parity};
      end
    end
  end

  // r(alpha) and r(alpha^3) of the word on the output
  always_comb begin
    cw_synd = '0;
    for (int j = 0; j < data_width + p_w; j++) begin
      if (codeword[j]) begin
        cw_synd.s1 = cw_synd.s1 ^ bch_pkg::gf_pow_alpha(j);
        cw_synd.s3 = cw_synd.s3 ^ bch_pkg::gf_pow_alpha(3 * j);
      end
    end
  end

  // alpha and alpha^3 are roots of g(x)
  // so every encoded word has zero syndromes
  a_enc_codeword : assert property (
    @(posedge clk) disable iff (!arst_n)
    out_valid |-> (cw_synd == '0)
  );

endmodule

// ==== design/bch_pkg.sv ====
// GF(32) polynomial basis with x^5+x^2+1; codeword length capped at 31 and data_width at 21

package bch_pkg;

  // ##########################################################
  // field and code constants
  // ##########################################################

  // field degree
  localparam int gf_m = 5;
  // natural length 2^m - 1
  localparam int gf_n = 31;
  // two minimal polynomials of degree 5
  localparam int parity_width = 10;
  // largest data word after shortening
  localparam int max_data_width = gf_n - parity_width;

  // low bits of x^5 + x^2 + 1
  // the x^5 term is implied by the shift out
  localparam logic [gf_m-1:0] gf_prim_low = 5'b00101;

  // g(x) = m1(x) * m3(x)
  // m1 = x^5+x^2+1 and m3 = x^5+x^4+x^3+x^2+1
  // x^10+x^9+x^8+x^6+x^5+x^3+1
  localparam logic [parity_width:0] gen_poly = 11'b111_0110_1001;

  // one field element
  typedef logic [gf_m-1:0] gf_t;

  // ##########################################################
  // shared structs
  // ##########################################################

  // syndromes of a received word
  typedef struct packed {
    gf_t s1;
    gf_t s3;
  } bch_synd_t;

  // decode outcome
  // err_cnt is 0 whenever uncorrectable is set
  typedef struct packed {
    logic [1:0] err_cnt;
    logic       uncorrectable;
  } bch_status_t;

  // ##########################################################
  // field arithmetic
  // ##########################################################

  // multiply by alpha
  // shift up and fold the x^5 term back
  function automatic gf_t gf_mul_alpha(gf_t a);
    gf_t r;
    r = {a[gf_m-2:0], 1'b0};
    if (a[gf_m-1]) begin
      r = r ^ gf_prim_low;
    end
    return r;
  endfunction

  // shift and add multiply
  function automatic gf_t gf_mul(gf_t a, gf_t b);
    gf_t acc;
    gf_t sh;
    acc = '0;
    sh  = a;
    for (int i = 0; i < gf_m; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      sh = gf_mul_alpha(sh);
    end
    return acc;
  endfunction

  function automatic gf_t gf_sq(gf_t a);
    return gf_mul(a, a);
  endfunction

  // a^-1 = a^30 = a^2 * a^4 * a^8 * a^16
  // zero maps to zero
  function automatic gf_t gf_inv(gf_t a);
    gf_t sq;
    gf_t r;
    sq = a;
    r  = gf_t'(1);
    for (int i = 1; i < gf_m; i++) begin
      sq = gf_sq(sq);
      r  = gf_mul(r, sq);
    end
    return r;
  endfunction

  // alpha^e with e reduced mod 31
  // only constant exponents in this design
  function automatic gf_t gf_pow_alpha(int unsigned e);
    gf_t         r;
    int unsigned k;
    r = gf_t'(1);
    k = e % gf_n;
    for (int unsigned i = 0; i < gf_n - 1; i++) begin
      if (i < k) begin
        r = gf_mul_alpha(r);
      end
    end
    return r;
  endfunction

endpackage
